// File: tb.f
+incdir+.
hwcnn_pkg.sv
hwcnn_bus_pkg.sv
apb_host_port.sv
topcontrol.sv
kernel_buffer.sv
feature_window.sv
conv_pe_core.sv
write2control.sv
hwcnn_top.sv
hwcnn_checker.sv
hwcnn_tb.sv

// File: hwcnn_tb.sv
`timescale 1ns/1ps
`include "hwcnn_params.svh"

module hwcnn_tb;
	import hwcnn_pkg::*;
	import hwcnn_bus_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int FEAT_NUM   = 1 << `HWCNN_FEAT_AW;
	localparam int KER_WORDS  = `HWCNN_KER_NUM * 9;
	localparam int RES_USED   = 31;  // Outputs written by the four jobs
	localparam int NUM_APB    = FEAT_NUM + KER_WORDS + RES_USED + 4;
	localparam int TOTAL_COLS = (12 + 2) + (6 + 2) + (5 + 2) + (8 + 2);
	localparam int NUM_INST   = 8;
	localparam int WD_CYCLES  = 2 * (5 * NUM_APB + TOTAL_COLS + 16 * NUM_INST) + 200;

	logic                      clk;
	logic                      arst_n;
	apb_req_t                  apb_req;
	apb_rsp_t                  apb_rsp;
	logic [`HWCNN_INST_W-1:0]  instruct;
	logic                      inst_empty;
	logic                      inst_req;
	logic                      busy;

	logic [`HWCNN_INST_W-1:0]  fifo_q [$];
	byte                       feat_m [FEAT_NUM];
	byte                       ker_m [KER_WORDS];
	int                        bias_m [`HWCNN_BIAS_NUM];
	int                        exp_res [1 << `HWCNN_RES_AW];
	int                        seed;
	int                        jobs_done;
	logic                      busy_prev;
	logic [`HWCNN_APB_DW-1:0]  rdata;

	hwcnn_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Failure reporting
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic value_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
		abort_run($sformatf("** Error: %s expected 0x%h, got 0x%h", name, exp, got));
	endtask

	//////////////////////////////////////////////////
	// APB master, one transfer
	task automatic apb_xfer(input logic wr, input logic [`HWCNN_APB_AW-1:0] addr,
			input logic [`HWCNN_APB_DW-1:0] wdata, input logic exp_err,
			output logic [`HWCNN_APB_DW-1:0] rd);
		int waits;
		@(negedge clk);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(negedge clk);
		apb_req.penable = 1'b1;
		waits = 0;
		do begin
			@(posedge clk);
			waits++;
		end while (!apb_rsp.pready && waits < 8);
		assert (apb_rsp.pready)
			else abort_run($sformatf("APB access to 0x%h never completed", addr));
		assert (apb_rsp.pslverr == exp_err)
			else value_mismatch("pslverr", 32'(exp_err), 32'(apb_rsp.pslverr));
		rd = apb_rsp.prdata;
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic check_result(input int a);
		apb_xfer(1'b0, `HWCNN_RES_BASE + 12'(a), '0, 1'b0, rdata);
		assert (rdata == 32'(exp_res[a]))
			else value_mismatch($sformatf("prdata[%0d]", a), 32'(exp_res[a]), rdata);
	endtask

	//////////////////////////////////////////////////
	// Reference model and instruction queueing
	function automatic int conv_ref(conv_inst_t c, int i);
		int acc;
		int fa;
		acc = bias_m[c.bias_idx];
		for (int r = 0; r < 3; r++)
			for (int k = 0; k < 3; k++) begin
				fa = (c.feat_start + r * c.line_len + i + k) % FEAT_NUM;
				acc += feat_m[fa] * ker_m[c.ker_idx * 9 + r * 3 + k];
			end
		acc = acc >>> c.shift;
		if (c.relu && acc < 0)
			acc = 0;
		if (acc > 32767)
			acc = 32767;
		else if (acc < -32768)
			acc = -32768;
		return acc;
	endfunction

	task automatic add_bias_inst(input logic [$clog2(`HWCNN_BIAS_NUM)-1:0] idx, input int val);
		bias_inst_t b;
		logic [`HWCNN_INST_W-1:0] w;
		b = '{op: LOAD_BIAS, bias_idx: idx, rsvd: '0, imm: val[`HWCNN_ACC_W-1:0]};
		w = `HWCNN_INST_W'(b);
		bias_m[idx] = val;
		@(posedge clk);
		fifo_q.push_back(w);
	endtask

	task automatic queue_conv(input conv_inst_t c);
		for (int i = 0; i < c.out_count; i++)
			exp_res[c.res_start + i] = conv_ref(c, i);
		@(posedge clk);
		fifo_q.push_back(c);
	endtask

	// Instruction FIFO, pops on inst_req
	initial begin
		instruct   = '0;
		inst_empty = 1'b1;
		forever begin
			@(negedge clk);
			inst_empty = (fifo_q.size() == 0);  // Queue state before this pop
			if (inst_req)
				instruct = fifo_q.pop_front();
		end
	end

	initial begin
		jobs_done = 0;
		busy_prev = 1'b0;
		forever begin
			@(negedge clk);
			if (busy_prev && !busy)
				jobs_done++;
			busy_prev = busy;
		end
	end

	always @(negedge clk)
		if (DUT.chk.fail_cnt != 0)
			abort_run("Protocol assertion in the checker failed");

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		abort_run("Watchdog expired before the tests finished");
	end

	//////////////////////////////////////////////////
	// Main sequence
	initial begin
		seed    = 43473;
		arst_n  = 1'b0;
		apb_req = '0;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;

		for (int a = 0; a < FEAT_NUM; a++) begin
			feat_m[a] = 8'($random(seed));
			apb_xfer(1'b1, `HWCNN_FEAT_BASE + 12'(a), 32'(feat_m[a]), 1'b0, rdata);
		end
		for (int a = 0; a < KER_WORDS; a++) begin
			ker_m[a] = 8'($random(seed));
			apb_xfer(1'b1, `HWCNN_KER_BASE + 12'(a), 32'(ker_m[a]), 1'b0, rdata);
		end

		add_bias_inst(2'd0, 100);
		add_bias_inst(2'd1, -300000);  // Forces negative saturation
		add_bias_inst(2'd2, 300000);
		add_bias_inst(2'd3, -50);

		queue_conv('{op: CONV, feat_start: 6'd3, line_len: 5'd16, out_count: 5'd12,
			ker_idx: 2'd0, bias_idx: 2'd0, shift: 5'd3, relu: 1'b1, res_start: 5'd0});
		wait (jobs_done == 1);
		queue_conv('{op: CONV, feat_start: 6'd0, line_len: 5'd20, out_count: 5'd6,
			ker_idx: 2'd1, bias_idx: 2'd1, shift: 5'd0, relu: 1'b0, res_start: 5'd12});
		wait (jobs_done == 2);

		// Back to back in the FIFO
		queue_conv('{op: CONV, feat_start: 6'd10, line_len: 5'd12, out_count: 5'd5,
			ker_idx: 2'd2, bias_idx: 2'd2, shift: 5'd0, relu: 1'b0, res_start: 5'd18});
		queue_conv('{op: CONV, feat_start: 6'd30, line_len: 5'd10, out_count: 5'd8,
			ker_idx: 2'd3, bias_idx: 2'd3, shift: 5'd2, relu: 1'b0, res_start: 5'd23});
		wait (jobs_done == 4);

		for (int a = 0; a < RES_USED; a++)
			check_result(a);

		// Rejected accesses leave results alone
		apb_xfer(1'b1, `HWCNN_RES_BASE + 12'd5, 32'h0000_7abc, 1'b1, rdata);
		check_result(5);
		apb_xfer(1'b0, `HWCNN_FEAT_BASE + 12'd7, '0, 1'b1, rdata);
		apb_xfer(1'b0, `HWCNN_RES_BASE + 12'd32, '0, 1'b1, rdata);

		repeat (4) @(negedge clk);
		if (DUT.chk.fail_cnt == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			abort_run("Protocol assertion in the checker failed");
		end
	end

endmodule

// File: hwcnn_checker.sv
`timescale 1ns/1ps
`include "hwcnn_params.svh"

module hwcnn_checker (
	input  logic                     clk,
	input  logic                     arst_n,
	input  hwcnn_bus_pkg::apb_req_t  apb_req,
	input  hwcnn_bus_pkg::apb_rsp_t  apb_rsp,
	input  logic                     inst_req,
	input  logic                     inst_empty,
	input  logic                     busy
);
	int                        fail_cnt = 0;
	logic                      setup;
	logic                      access;
	logic [`HWCNN_APB_AW-1:0]  feat_off;
	logic [`HWCNN_APB_AW-1:0]  res_off;
	logic                      in_feat;
	logic                      in_res;

	assign setup    = apb_req.psel && !apb_req.penable;
	assign access   = apb_req.psel && apb_req.penable;
	assign feat_off = `HWCNN_APB_AW'(apb_req.paddr - `HWCNN_FEAT_BASE);
	assign res_off  = `HWCNN_APB_AW'(apb_req.paddr - `HWCNN_RES_BASE);
	assign in_feat  = feat_off < (1 << `HWCNN_FEAT_AW);
	assign in_res   = res_off < (1 << `HWCNN_RES_AW);

	//////////////////////////////////////////////////
	// Reset and instruction fetch
	a_reset_quiet: assert property (@(posedge clk)
		(!arst_n || $rose(arst_n)) |-> !inst_req && !busy && !apb_rsp.pready && !apb_rsp.pslverr)
		else begin
			fail_cnt++;
			$error("Outputs active during or right after reset");
		end

	a_req_idle: assert property (@(posedge clk) disable iff (!arst_n)
		inst_req |-> !busy && !inst_empty)
		else begin
			fail_cnt++;
			$error("inst_req raised while busy or with the FIFO empty");
		end

	//////////////////////////////////////////////////
	// APB timing and errors
	a_wr_no_wait: assert property (@(posedge clk) disable iff (!arst_n)
		(setup && apb_req.pwrite) |=> apb_rsp.pready)
		else begin
			fail_cnt++;
			$error("APB write not ready in its first access cycle");
		end

	a_rd_one_wait: assert property (@(posedge clk) disable iff (!arst_n)
		(setup && !apb_req.pwrite && in_res) |=>
		!apb_rsp.pready ##1 (apb_rsp.pready && !apb_rsp.pslverr))
		else begin
			fail_cnt++;
			$error("Result read did not complete in its second access cycle");
		end

	a_bad_write: assert property (@(posedge clk) disable iff (!arst_n)
		(access && apb_req.pwrite && in_res) |-> apb_rsp.pready && apb_rsp.pslverr)
		else begin
			fail_cnt++;
			$error("Write to the result region not rejected");
		end

	a_bad_read: assert property (@(posedge clk) disable iff (!arst_n)
		(access && !apb_req.pwrite && in_feat) |-> apb_rsp.pready && apb_rsp.pslverr)
		else begin
			fail_cnt++;
			$error("Read from the feature region not rejected");
		end

endmodule

bind hwcnn_top hwcnn_checker chk (
	.clk        (clk),
	.arst_n     (arst_n),
	.apb_req    (apb_req),
	.apb_rsp    (apb_rsp),
	.inst_req   (inst_req),
	.inst_empty (inst_empty),
	.busy       (busy)
);

// File: hwcnn_top.sv
`timescale 1ns/1ps
`include "hwcnn_params.svh"

module hwcnn_top (
	input  logic                        clk,
	input  logic                        arst_n,
	input  hwcnn_bus_pkg::apb_req_t     apb_req,
	output hwcnn_bus_pkg::apb_rsp_t     apb_rsp,
	input  logic [`HWCNN_INST_W-1:0]    instruct,
	input  logic                        inst_empty,
	output logic                        inst_req,
	output logic                        busy
);
	import hwcnn_pkg::*;

	logic                                    feat_wr_en;
	logic [`HWCNN_FEAT_AW-1:0]               feat_wr_addr;
	logic [`HWCNN_DATA_W-1:0]                feat_wr_data;
	logic                                    ker_wr_en;
	logic [$clog2(`HWCNN_KER_NUM*9)-1:0]     ker_wr_addr;
	logic [`HWCNN_DATA_W-1:0]                ker_wr_data;
	logic [`HWCNN_RES_AW-1:0]                res_rd_addr;
	logic [`HWCNN_RES_W-1:0]                 res_rd_data;
	logic [2:0][`HWCNN_FEAT_AW-1:0]          col_addr;
	logic                                    col_valid;
	logic [$clog2(`HWCNN_KER_NUM)-1:0]       ker_idx;
	pe_ctrl_t                                pe_ctrl;
	logic                                    job_start;
	logic [`HWCNN_RES_AW-1:0]                res_start;
	logic [`HWCNN_LINE_W-1:0]                out_count;
	logic                                    job_done;
	window_t                                 window;
	logic                                    window_valid;
	kernel_t                                 kernel;
	logic signed [`HWCNN_RES_W-1:0]          result;
	logic                                    result_valid;

	apb_host_port hport (.*);

	topcontrol tctrl (.*);

	kernel_buffer kbuf (.*);

	feature_window fwin (.*);

	conv_pe_core pec (.*);

	write2control w2c (.*);

endmodule

// File: write2control.sv
`timescale 1ns/1ps
`include "hwcnn_params.svh"

module write2control (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            job_start,
	input  logic [`HWCNN_RES_AW-1:0]        res_start,
	input  logic [`HWCNN_LINE_W-1:0]        out_count,
	input  logic signed [`HWCNN_RES_W-1:0]  result,
	input  logic                            result_valid,
	input  logic [`HWCNN_RES_AW-1:0]        res_rd_addr,
	output logic [`HWCNN_RES_W-1:0]         res_rd_data,
	output logic                            job_done
);
	logic [`HWCNN_RES_W-1:0]   res_mem [0:(1<<`HWCNN_RES_AW)-1];
	logic [`HWCNN_RES_AW-1:0]  wr_addr;
	logic [`HWCNN_LINE_W-1:0]  remain;  // Results still due in this job

	assign job_done = result_valid && (remain == `HWCNN_LINE_W'(1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_addr <= '0;
			remain  <= '0;
		end else if (job_start) begin
			wr_addr <= res_start;
			remain  <= out_count;
		end else if (result_valid) begin
			wr_addr <= wr_addr + 1'b1;
			remain  <= remain - 1'b1;
		end
	end

	// Write port from the PE, registered read port for the host
	always_ff @(posedge clk) begin
		if (result_valid)
			res_mem[wr_addr] <= result;
		res_rd_data <= res_mem[res_rd_addr];
	end

endmodule

// File: conv_pe_core.sv
`timescale 1ns/1ps
`include "hwcnn_params.svh"

module conv_pe_core (
	input  logic                            clk,
	input  logic                            arst_n,
	input  hwcnn_pkg::window_t              window,
	input  logic                            window_valid,
	input  hwcnn_pkg::kernel_t              kernel,
	input  hwcnn_pkg::pe_ctrl_t             pe_ctrl,
	output logic signed [`HWCNN_RES_W-1:0]  result,
	output logic                            result_valid
);
	import hwcnn_pkg::*;

	localparam int PROD_W  = 2 * `HWCNN_DATA_W;
	localparam int SUM_W   = `HWCNN_ACC_W + 1;  // Headroom for bias add
	localparam int RES_MAX = (1 << (`HWCNN_RES_W - 1)) - 1;
	localparam int RES_MIN = -(1 << (`HWCNN_RES_W - 1));

	logic signed [PROD_W-1:0]        prod_q [9];
	pe_ctrl_t                        ctrl_s1;
	pe_ctrl_t                        ctrl_s2;
	logic                            valid_s1;
	logic                            valid_s2;
	logic signed [SUM_W-1:0]         sum_d;
	logic signed [SUM_W-1:0]         sum_q;
	logic signed [SUM_W-1:0]         shifted;
	logic signed [`HWCNN_RES_W-1:0]  res_d;

	//////////////////////////////////////////////////
	// Adder tree plus bias, then shift/ReLU/saturate
	always_comb begin
		sum_d = SUM_W'(ctrl_s1.bias);
		for (int i = 0; i < 9; i++)
			sum_d = sum_d + SUM_W'(prod_q[i]);
	end

	always_comb begin
		shifted = sum_q >>> ctrl_s2.shift;
		if (ctrl_s2.relu && shifted < 0)
			res_d = '0;
		else if (shifted > RES_MAX)
			res_d = `HWCNN_RES_W'(RES_MAX);
		else if (shifted < RES_MIN)
			res_d = `HWCNN_RES_W'(RES_MIN);
		else
			res_d = `HWCNN_RES_W'(shifted);
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 9; i++)
			prod_q[i] <= window[i] * kernel[i];  // Stage 1
		ctrl_s1 <= pe_ctrl;
		sum_q   <= sum_d;  // Stage 2
		ctrl_s2 <= ctrl_s1;
		result  <= res_d;  // Stage 3
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_s1     <= 1'b0;
			valid_s2     <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			valid_s1     <= window_valid;
			valid_s2     <= valid_s1;
			result_valid <= valid_s2;
		end
	end

endmodule

// File: feature_window.sv
`timescale 1ns/1ps
`include "hwcnn_params.svh"

module feature_window (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            feat_wr_en,
	input  logic [`HWCNN_FEAT_AW-1:0]       feat_wr_addr,
	input  logic [`HWCNN_DATA_W-1:0]        feat_wr_data,
	input  logic [2:0][`HWCNN_FEAT_AW-1:0]  col_addr,
	input  logic                            col_valid,
	output hwcnn_pkg::window_t              window,
	output logic                            window_valid
);
	import hwcnn_pkg::*;

	data_t             feat_mem [0:(1<<`HWCNN_FEAT_AW)-1];
	data_t [2:0]       rd_col;     // One column, index is row
	data_t [2:0][2:0]  shift_col;  // [column][row], column 0 oldest
	logic              rd_valid;
	logic [1:0]        col_cnt;

	always_ff @(posedge clk) begin
		if (feat_wr_en)
			feat_mem[feat_wr_addr] <= feat_wr_data;
		if (col_valid) begin
			for (int r = 0; r < 3; r++)
				rd_col[r] <= feat_mem[col_addr[r]];
		end
		if (rd_valid)
			shift_col <= {rd_col, shift_col[2:1]};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_valid     <= 1'b0;
			col_cnt      <= '0;
			window_valid <= 1'b0;
		end else begin
			rd_valid     <= col_valid;
			window_valid <= rd_valid && (col_cnt == 2'd2);  // Third column onward
			if (!rd_valid)
				col_cnt <= '0;
			else if (col_cnt != 2'd2)
				col_cnt <= col_cnt + 1'b1;
		end
	end

	always_comb begin
		for (int r = 0; r < 3; r++)
			for (int c = 0; c < 3; c++)
				window[r*3 + c] = shift_col[c][r];
	end

endmodule

// File: kernel_buffer.sv
`timescale 1ns/1ps
`include "hwcnn_params.svh"

module kernel_buffer (
	input  logic                                 clk,
	input  logic                                 ker_wr_en,
	input  logic [$clog2(`HWCNN_KER_NUM*9)-1:0]  ker_wr_addr,
	input  logic [`HWCNN_DATA_W-1:0]             ker_wr_data,
	input  logic [$clog2(`HWCNN_KER_NUM)-1:0]    ker_idx,
	output hwcnn_pkg::kernel_t                   kernel
);
	import hwcnn_pkg::*;

	data_t ker_mem [0:`HWCNN_KER_NUM*9-1];  // Nine taps per kernel, row major

	always_ff @(posedge clk) begin
		if (ker_wr_en)
			ker_mem[ker_wr_addr] <= ker_wr_data;
	end

	// All taps of one kernel in a single read
	always_ff @(posedge clk) begin
		for (int t = 0; t < 9; t++)
			kernel[t] <= ker_mem[ker_idx * 9 + t];
	end

endmodule

// File: topcontrol.sv
`timescale 1ns/1ps
`include "hwcnn_params.svh"

module topcontrol (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic [`HWCNN_INST_W-1:0]           instruct,
	input  logic                               inst_empty,
	output logic                               inst_req,
	output logic [2:0][`HWCNN_FEAT_AW-1:0]     col_addr,
	output logic                               col_valid,
	output logic [$clog2(`HWCNN_KER_NUM)-1:0]  ker_idx,
	output hwcnn_pkg::pe_ctrl_t                pe_ctrl,
	output logic                               job_start,
	output logic [`HWCNN_RES_AW-1:0]           res_start,
	output logic [`HWCNN_LINE_W-1:0]           out_count,
	input  logic                               job_done,
	output logic                               busy
);
	import hwcnn_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_REQ,
		ST_FETCH,  // instruct valid from FIFO
		ST_RUN,
		ST_DRAIN   // Window and PE pipeline emptying
	} state_e;

	state_e                          state;
	inst_word_u                      inst_w;
	conv_inst_t                      conv_q;
	logic signed [`HWCNN_ACC_W-1:0]  bias_rf [`HWCNN_BIAS_NUM];
	logic [`HWCNN_LINE_W:0]          col_cnt;

	assign inst_w    = instruct;
	assign inst_req  = (state == ST_REQ);
	assign busy      = (state == ST_RUN) || (state == ST_DRAIN);
	assign col_valid = (state == ST_RUN);

	//////////////////////////////////////////////////
	// Fetch and job sequencing
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			col_cnt   <= '0;
			job_start <= 1'b0;
		end else begin
			job_start <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (!inst_empty)
						state <= ST_REQ;
				end
				ST_REQ: state <= ST_FETCH;
				ST_FETCH: begin
					if (inst_w.conv.op == CONV) begin
						state     <= ST_RUN;
						col_cnt   <= '0;
						job_start <= 1'b1;
					end else begin
						state <= ST_IDLE;
					end
				end
				ST_RUN: begin
					col_cnt <= col_cnt + 1'b1;
					if (col_cnt == conv_q.out_count + 1'b1)  // N+2 columns issued
						state <= ST_DRAIN;
				end
				ST_DRAIN: begin
					if (job_done)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_FETCH && inst_w.conv.op == CONV)
			conv_q <= inst_w.conv;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `HWCNN_BIAS_NUM; i++)
				bias_rf[i] <= '0;
		end else if (state == ST_FETCH && inst_w.bias.op == LOAD_BIAS) begin
			bias_rf[inst_w.bias.bias_idx] <= inst_w.bias.imm;
		end
	end

	//////////////////////////////////////////////////
	// Job parameters held until done
	always_comb begin
		for (int r = 0; r < 3; r++)
			col_addr[r] = `HWCNN_FEAT_AW'(conv_q.feat_start + r * conv_q.line_len + col_cnt);
	end

	assign ker_idx   = conv_q.ker_idx;
	assign res_start = conv_q.res_start;
	assign out_count = conv_q.out_count;
	assign pe_ctrl   = '{bias: bias_rf[conv_q.bias_idx], shift: conv_q.shift, relu: conv_q.relu};

endmodule

// File: apb_host_port.sv
`timescale 1ns/1ps
`include "hwcnn_params.svh"

module apb_host_port (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  hwcnn_bus_pkg::apb_req_t              apb_req,
	output hwcnn_bus_pkg::apb_rsp_t              apb_rsp,
	output logic                                 feat_wr_en,
	output logic [`HWCNN_FEAT_AW-1:0]            feat_wr_addr,
	output logic [`HWCNN_DATA_W-1:0]             feat_wr_data,
	output logic                                 ker_wr_en,
	output logic [$clog2(`HWCNN_KER_NUM*9)-1:0]  ker_wr_addr,
	output logic [`HWCNN_DATA_W-1:0]             ker_wr_data,
	output logic [`HWCNN_RES_AW-1:0]             res_rd_addr,
	input  logic [`HWCNN_RES_W-1:0]              res_rd_data
);
	localparam int KER_DEPTH = `HWCNN_KER_NUM * 9;

	logic [`HWCNN_APB_AW-1:0] feat_off;
	logic [`HWCNN_APB_AW-1:0] ker_off;
	logic [`HWCNN_APB_AW-1:0] res_off;
	logic                     access;
	logic                     bad;
	logic                     rd_wait;  // Result read in its wait state

	assign access   = apb_req.psel && apb_req.penable;
	assign feat_off = apb_req.paddr - `HWCNN_FEAT_BASE;  // Wraps high below base
	assign ker_off  = apb_req.paddr - `HWCNN_KER_BASE;
	assign res_off  = apb_req.paddr - `HWCNN_RES_BASE;

	// Writes only to feature/kernel, reads only from result
	assign bad = apb_req.pwrite ? !(feat_off < (1 << `HWCNN_FEAT_AW) || ker_off < KER_DEPTH)
	                            : !(res_off < (1 << `HWCNN_RES_AW));

	assign feat_wr_en   = access && apb_req.pwrite && (feat_off < (1 << `HWCNN_FEAT_AW));
	assign feat_wr_addr = feat_off[`HWCNN_FEAT_AW-1:0];
	assign feat_wr_data = apb_req.pwdata[`HWCNN_DATA_W-1:0];
	assign ker_wr_en    = access && apb_req.pwrite && (ker_off < KER_DEPTH);
	assign ker_wr_addr  = ker_off[$clog2(KER_DEPTH)-1:0];
	assign ker_wr_data  = apb_req.pwdata[`HWCNN_DATA_W-1:0];
	assign res_rd_addr  = res_off[`HWCNN_RES_AW-1:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rd_wait <= 1'b0;
		else
			rd_wait <= access && !apb_req.pwrite && !bad && !rd_wait;
	end

	always_comb begin
		apb_rsp.pready  = access && (apb_req.pwrite || bad || rd_wait);
		apb_rsp.pslverr = access && bad;
		apb_rsp.prdata  = rd_wait ? `HWCNN_APB_DW'($signed(res_rd_data)) : '0;
	end

endmodule

// File: hwcnn_bus_pkg.sv
`include "hwcnn_params.svh"

package hwcnn_bus_pkg;

	typedef struct packed {
		logic                      psel;
		logic                      penable;
		logic                      pwrite;
		logic [`HWCNN_APB_AW-1:0]  paddr;
		logic [`HWCNN_APB_DW-1:0]  pwdata;
	} apb_req_t;

	typedef struct packed {
		logic                      pready;
		logic [`HWCNN_APB_DW-1:0]  prdata;
		logic                      pslverr;
	} apb_rsp_t;

endpackage

// File: hwcnn_pkg.sv
`include "hwcnn_params.svh"

package hwcnn_pkg;

	typedef enum logic {
		CONV      = 1'b0,
		LOAD_BIAS = 1'b1
	} inst_op_e;

	typedef logic signed [`HWCNN_DATA_W-1:0] data_t;

	// CONV form, fields from MSB down
	typedef struct packed {
		inst_op_e                            op;
		logic [`HWCNN_FEAT_AW-1:0]           feat_start;
		logic [`HWCNN_LINE_W-1:0]            line_len;
		logic [`HWCNN_LINE_W-1:0]            out_count;
		logic [$clog2(`HWCNN_KER_NUM)-1:0]   ker_idx;
		logic [$clog2(`HWCNN_BIAS_NUM)-1:0]  bias_idx;
		logic [$clog2(`HWCNN_ACC_W)-1:0]     shift;
		logic                                relu;
		logic [`HWCNN_RES_AW-1:0]            res_start;
	} conv_inst_t;

	// LOAD_BIAS form
	typedef struct packed {
		inst_op_e                                                          op;
		logic [$clog2(`HWCNN_BIAS_NUM)-1:0]                                bias_idx;
		logic [`HWCNN_INST_W-1-$clog2(`HWCNN_BIAS_NUM)-`HWCNN_ACC_W-1:0]  rsvd;
		logic signed [`HWCNN_ACC_W-1:0]                                    imm;
	} bias_inst_t;

	typedef union packed {
		conv_inst_t conv;
		bias_inst_t bias;
	} inst_word_u;

	typedef data_t [8:0] window_t;  // Index row*3 + col
	typedef data_t [8:0] kernel_t;

	typedef struct packed {
		logic signed [`HWCNN_ACC_W-1:0]   bias;
		logic [$clog2(`HWCNN_ACC_W)-1:0]  shift;
		logic                             relu;
	} pe_ctrl_t;

endpackage

// File: hwcnn_params.svh
`ifndef HWCNN_PARAMS_SVH
`define HWCNN_PARAMS_SVH

//////////////////////////////////////////////////
// Storage sizes
`define HWCNN_FEAT_AW   6    // 64 feature bytes
`define HWCNN_KER_NUM   4
`define HWCNN_BIAS_NUM  4
`define HWCNN_RES_AW    5

//////////////////////////////////////////////////
// Datapath widths
`define HWCNN_DATA_W    8    // Signed features and weights
`define HWCNN_ACC_W     20
`define HWCNN_RES_W     16
`define HWCNN_LINE_W    5
`define HWCNN_INST_W    32

//////////////////////////////////////////////////
// APB host port and address map, one entry per address
`define HWCNN_APB_AW    12
`define HWCNN_APB_DW    32
`define HWCNN_FEAT_BASE 12'h000
`define HWCNN_KER_BASE  12'h100  // kernel*9 + tap
`define HWCNN_RES_BASE  12'h200

`endif
